//--- boot_rom.mem
// One 16-bit word per line, word 0 sits at 0xF00000
4ff9
0000
8000
41f9
00f0
0040
43f9
0020
0000
303c
000f
32d8
51c8
fffc
4eb9
00f0
0050
60fe
2f08
7000
1018
6706
13c0
0032
0000
60f4
205f
4e75
4341
5244
4e4f
2d49
4155
544f
504c
4159
0000
1234
5678
9abc
def0
0f1e
2d3c
4b5a
6978
8796
a5b4
c3d2
e1f0
0102
0304
a55a
c0de

//--- run_sim.sh
#!/bin/sh
# Build and run the bus glue testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_top -f tb.f --Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_top)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST PASS"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- source/address_decoder.sv
`default_nettype none

module address_decoder (
    input  cdi_bus_pkg::addr_t   addr,
    input  logic                 as,
    input  logic                 rom_active,
    output cdi_bus_pkg::region_e region
);
    import cdi_bus_pkg::*;

    logic err_area1;
    logic err_area2;
    logic err_area3;
    logic err_rom_off;
    logic in_error;
    logic video_cs;
    logic dvc_ram_cs;
    logic dvc_rom_cs;
    logic nvram_cs;
    logic rom_window;

    // Unmapped RAM areas of the board
    assign err_area1 = (addr >= ERR1_START) && (addr < ERR1_END);
    assign err_area2 = (addr >= ERR2_START) && (addr < ERR2_END);
    assign err_area3 = (addr >= ERR3_START);
    assign err_rom_off = (addr >= BOOT_ROM_START) && !rom_active;  // ROM window while inactive
    assign in_error = err_area1 || err_area2 || err_area3 || err_rom_off;

    // Main video range, lower half of the map only
    assign video_cs = ((addr <= VIDEO_LOW_END) || (addr >= VIDEO_HIGH_START)) && !addr[23];
    assign dvc_ram_cs = (addr[23:20] == DVC_RAM_NIBBLE) || (addr[23:19] == DVC_RAM2_PREFIX);
    assign dvc_rom_cs = (addr[23:18] == DVC_ROM_PREFIX);

    assign nvram_cs = (addr[23:16] == NVRAM_PAGE);
    assign rom_window = (addr >= BOOT_ROM_START) && (addr <= BOOT_ROM_END) && rom_active;

    // Priority follows the order of the checks
    always_comb begin
        region = REGION_OPEN;  // Idle bus and unclaimed areas
        if (as) begin
            if (in_error) begin
                region = REGION_ERROR;
            end else if (video_cs || dvc_ram_cs || dvc_rom_cs) begin
                region = REGION_VIDEO;
            end else if (nvram_cs) begin
                region = REGION_NVRAM;
            end else if (rom_window) begin
                region = REGION_BOOT_ROM;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/boot_rom.sv
`default_nettype none

module boot_rom (
    input  logic               clk30,
    input  logic               reset,
    cpu_bus_if.rom             bus,
    input  logic               cd_img_mounted,
    input  logic               auto_play,
    input  logic               audio_cd_in_tray,
    input  logic               slave_reset,
    output logic               rom_active,
    output cdi_bus_pkg::data_t rdata,
    output logic               ack
);
    import cdi_bus_pkg::*;

    data_t rom[BOOT_ROM_WORDS];
    logic last_reset_by_slave;

    initial $readmemh("boot_rom.mem", rom);

    // A reset requested by the slave means the system shell was asked for,
    // so auto play stays off until the next board reset
    always_ff @(posedge clk30) begin
        if (reset) begin
            last_reset_by_slave <= 1'b0;
        end else if (slave_reset) begin
            last_reset_by_slave <= 1'b1;
        end
    end

    assign rom_active = cd_img_mounted && auto_play && !audio_cd_in_tray && !last_reset_by_slave;

    always_ff @(posedge clk30) begin
        if (bus.rom_sel) rdata <= rom[bus.waddr[BOOT_ROM_INDEX_BITS:1]];  // Word inside window

        if (reset) begin
            ack <= 1'b0;
        end else begin
            ack <= bus.rom_sel && !ack;  // One wait state, then a single pulse
        end
    end

endmodule

`default_nettype wire

//--- source/bus_glue_top.sv
`default_nettype none

module bus_glue_top (
    input  logic               clk30,
    input  logic               reset,
    input  cdi_bus_pkg::addr_t addr,
    input  logic               as,
    input  logic               uds,
    input  logic               lds,
    input  logic               write_strobe,
    input  cdi_bus_pkg::data_t wdata,
    output cdi_bus_pkg::data_t rdata,
    output logic               bus_ack,
    output logic               bus_err,
    output logic               ext_req,
    output logic               ext_write,
    output cdi_bus_pkg::addr_t ext_addr,
    input  cdi_bus_pkg::data_t ext_rdata,
    input  logic               ext_ack,
    input  logic               cd_img_mounted,
    input  logic               auto_play,
    input  logic               audio_cd_in_tray,
    input  logic               slave_reset,
    input  logic               cdic_intreq,
    input  logic               vmpeg_intreq,
    input  logic               iack4,
    output logic               int4
);
    import cdi_bus_pkg::*;

    region_e region;
    logic rom_active;
    data_t rom_rdata;
    logic rom_ack;
    byte_t nvram_rdata;
    logic nvram_ack;
    logic vector_valid;
    data_t vector;

    cpu_bus_if bus_if ();

    assign bus_if.waddr = addr[ADDR_WIDTH-1:1];
    assign bus_if.wdata = wdata;
    assign bus_if.write = write_strobe;
    assign bus_if.uds = uds;
    assign bus_if.lds = lds;
    assign bus_if.nvram_sel = (region == REGION_NVRAM);
    assign bus_if.rom_sel = (region == REGION_BOOT_ROM);

    address_decoder address_decoder_i (
        .addr,
        .as,
        .rom_active,
        .region
    );

    boot_rom boot_rom_i (
        .clk30,
        .reset,
        .bus(bus_if.rom),
        .cd_img_mounted,
        .auto_play,
        .audio_cd_in_tray,
        .slave_reset,
        .rom_active,
        .rdata(rom_rdata),
        .ack(rom_ack)
    );

    nvram_store nvram_store_i (
        .clk30,
        .reset,
        .bus(bus_if.nvram),
        .rdata(nvram_rdata),
        .ack(nvram_ack)
    );

    irq4_arbiter irq4_arbiter_i (
        .clk30,
        .reset,
        .cdic_intreq,
        .vmpeg_intreq,
        .iack4,
        .int4,
        .vector_valid,
        .vector
    );

    // Video ranges go out to the external memory port
    assign ext_req = (region == REGION_VIDEO);
    assign ext_write = ext_req && write_strobe;
    assign ext_addr = addr;

    // A vector cycle is never a bus error
    assign bus_err = (region == REGION_ERROR) && (uds || lds) && !vector_valid;

    always_comb begin
        rdata = '0;
        bus_ack = 1'b0;
        if (as) begin
            case (region)
                REGION_VIDEO: begin
                    rdata = ext_rdata;
                    bus_ack = ext_ack;
                end
                REGION_NVRAM: begin
                    rdata = {nvram_rdata, nvram_rdata};  // Same byte on both lanes
                    bus_ack = nvram_ack;
                end
                REGION_BOOT_ROM: begin
                    rdata = rom_rdata;
                    bus_ack = rom_ack;
                end
                REGION_OPEN: bus_ack = 1'b1;  // Open bus reads zero
                default: ;
            endcase
        end

        if (vector_valid) begin
            rdata = vector;
            bus_ack = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- source/cdi_bus_pkg.sv
`default_nettype none

package cdi_bus_pkg;

    localparam int ADDR_WIDTH = 24;
    localparam int DATA_WIDTH = 16;

    typedef logic [ADDR_WIDTH-1:0] addr_t;  // Byte address, word address is [23:1]
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [7:0] byte_t;

    typedef enum logic [2:0] {
        REGION_VIDEO,
        REGION_NVRAM,
        REGION_BOOT_ROM,
        REGION_OPEN,
        REGION_ERROR
    } region_e;

    // Owner of the shared level-4 line
    typedef enum logic [1:0] {
        OWNER_IDLE,
        OWNER_CDIC,
        OWNER_VMPEG
    } irq_owner_e;

    // Video controller ranges
    localparam addr_t VIDEO_LOW_END = 24'h27FFFF;
    localparam addr_t VIDEO_HIGH_START = 24'h400000;
    localparam logic [3:0] DVC_RAM_NIBBLE = 4'hD;
    localparam logic [4:0] DVC_RAM2_PREFIX = 5'b11101;
    localparam logic [5:0] DVC_ROM_PREFIX = 6'b111001;

    localparam logic [7:0] NVRAM_PAGE = 8'h32;
    localparam int NVRAM_ADDR_BITS = 13;
    localparam int NVRAM_BYTES = 1 << NVRAM_ADDR_BITS;

    localparam addr_t BOOT_ROM_START = 24'hF00000;
    localparam addr_t BOOT_ROM_END = 24'hF00068;  // Inclusive, last word
    localparam int BOOT_ROM_WORDS = 53;
    localparam int BOOT_ROM_INDEX_BITS = $clog2(BOOT_ROM_WORDS);

    // Unmapped areas
    localparam addr_t ERR1_START = 24'h080000;
    localparam addr_t ERR1_END = 24'h200000;
    localparam addr_t ERR2_START = 24'h500000;
    localparam addr_t ERR2_END = 24'hD00000;
    localparam addr_t ERR3_START = 24'hF10000;

    localparam data_t CDIC_VECTOR = 16'h0080;
    localparam data_t VMPEG_VECTOR = 16'h0081;

endpackage

`default_nettype wire

//--- source/cpu_bus_if.sv
`default_nettype none

// One decoded CPU access, shared by the memories
interface cpu_bus_if;
    import cdi_bus_pkg::*;

    logic [ADDR_WIDTH-1:1] waddr;  // Word address
    data_t wdata;
    logic write;
    logic uds;
    logic lds;
    logic nvram_sel;
    logic rom_sel;

    modport host(output waddr, output wdata, output write, output uds, output lds,
                 output nvram_sel, output rom_sel);

    modport nvram(input waddr, input wdata, input write, input uds, input lds, input nvram_sel);

    modport rom(input waddr, input wdata, input write, input uds, input lds, input rom_sel);

endinterface

`default_nettype wire

//--- source/irq4_arbiter.sv
`default_nettype none

// Shared level-4 line, modeled on the board's small SR flip-flop
module irq4_arbiter (
    input  logic               clk30,
    input  logic               reset,
    input  logic               cdic_intreq,
    input  logic               vmpeg_intreq,
    input  logic               iack4,
    output logic               int4,
    output logic               vector_valid,
    output cdi_bus_pkg::data_t vector
);
    import cdi_bus_pkg::*;

    irq_owner_e owner;

    always_ff @(posedge clk30) begin
        if (reset) begin
            owner <= OWNER_IDLE;
        end else begin
            case (owner)
                OWNER_CDIC: begin
                    if (!cdic_intreq) owner <= OWNER_IDLE;
                end
                OWNER_VMPEG: begin
                    if (!vmpeg_intreq) owner <= OWNER_IDLE;
                end
                default: begin
                    if (vmpeg_intreq) owner <= OWNER_VMPEG;  // VMPEG wins a tie
                    else if (cdic_intreq) owner <= OWNER_CDIC;
                end
            endcase
        end
    end

    assign int4 = ((owner == OWNER_CDIC) && cdic_intreq) ||
                  ((owner == OWNER_VMPEG) && vmpeg_intreq);

    always_comb begin
        vector_valid = 1'b0;
        vector = '0;
        case (owner)
            OWNER_CDIC: begin
                vector_valid = iack4;
                vector = CDIC_VECTOR;
            end
            OWNER_VMPEG: begin
                vector_valid = iack4;
                vector = VMPEG_VECTOR;
            end
            default: ;  // No owner, no vector
        endcase
    end

endmodule

`default_nettype wire

//--- source/nvram_store.sv
`default_nettype none

module nvram_store (
    input  logic               clk30,
    input  logic               reset,
    cpu_bus_if.nvram           bus,
    output cdi_bus_pkg::byte_t rdata,
    output logic               ack
);
    import cdi_bus_pkg::*;

    byte_t mem[NVRAM_BYTES];
    logic [NVRAM_ADDR_BITS-1:0] index;
    logic do_write;

    // Byte per word, the chip sits on the upper lane only
    assign index = bus.waddr[NVRAM_ADDR_BITS:1];
    assign do_write = bus.nvram_sel && bus.write && bus.uds && !ack;

    always_ff @(posedge clk30) begin
        if (do_write) begin
            mem[index] <= bus.wdata[15:8];
        end
        rdata <= mem[index];  // Ready with ack
    end

    // Acknowledge once per access
    always_ff @(posedge clk30) begin
        if (reset) begin
            ack <= 1'b0;
        end else begin
            ack <= bus.nvram_sel && !ack;
        end
    end

endmodule

`default_nettype wire

//--- tb.f
source/cdi_bus_pkg.sv
source/cpu_bus_if.sv
source/address_decoder.sv
source/boot_rom.sv
source/nvram_store.sv
source/irq4_arbiter.sv
source/bus_glue_top.sv
testbench/tb_clock.sv
testbench/tb_top.sv

//--- testbench/tb_clock.sv
`default_nettype none

// Free running board clock
module tb_clock (
    output logic clk30
);
    localparam int HALF_PERIOD = 10;

    initial begin
        clk30 = 1'b0;
        forever #HALF_PERIOD clk30 = ~clk30;
    end

endmodule

`default_nettype wire

//--- testbench/tb_top.sv
`default_nettype none

module tb_top;
    localparam int BUS_TIMEOUT = 20;  // Cycles before a wait gives up
    localparam int NVRAM_WRITES = 24;
    localparam logic [15:0] CDIC_VEC = 16'h0080;
    localparam logic [15:0] VMPEG_VEC = 16'h0081;

    logic clk30;
    logic reset;
    logic [23:0] addr;
    logic as;
    logic uds;
    logic lds;
    logic write_strobe;
    logic [15:0] wdata;
    logic [15:0] rdata;
    logic bus_ack;
    logic bus_err;
    logic ext_req;
    logic ext_write;
    logic [23:0] ext_addr;
    logic [15:0] ext_rdata;
    logic ext_ack;
    logic cd_img_mounted;
    logic auto_play;
    logic audio_cd_in_tray;
    logic slave_reset;
    logic cdic_intreq;
    logic vmpeg_intreq;
    logic iack4;
    logic int4;

    int errors;
    int sva_errors;
    int checks;
    int test_errors;
    int test_checks;
    int ext_delay;
    int ext_wait;

    // Result of the last bus cycle
    logic [15:0] got_data;
    logic got_ack;
    logic got_err;
    int got_cycles;
    logic got_ext_req;
    logic got_ext_write;
    logic [23:0] got_ext_addr;

    logic [15:0] rom_image [53];
    logic [7:0] nv_model [8192];  // Expected NVRAM bytes
    logic [12:0] nv_index [$];
    logic [23:0] err_addrs [8] = '{24'h080000, 24'h1ffffe, 24'h500000, 24'hcffffe,
                                   24'hf10000, 24'hfffffe, 24'hf00000, 24'hf00068};
    logic [23:0] video_addrs [6] = '{24'h000100, 24'h27fffe, 24'h400010, 24'hd00020,
                                     24'he40000, 24'he80100};

    tb_clock tb_clock_i (.clk30);

    bus_glue_top bus_glue_top_i (.*);

    // Video memory contents, every address bit takes part
    function automatic logic [15:0] video_fill(input logic [23:0] a);
        return {a[23:16], 8'h00} ^ a[15:0] ^ 16'h5a5a;
    endfunction

    // Video controller ranges of the board map, after the bus error areas
    function automatic logic video_area(input logic [23:0] a);
        return (a < 24'h080000) || (a >= 24'h200000 && a <= 24'h27ffff) ||
               (a >= 24'h400000 && a < 24'h500000) || (a[23:20] == 4'hd) ||
               (a >= 24'he40000 && a < 24'hf00000);
    endfunction

    // With one master each acknowledge lasts a single cycle
    assert property (@(posedge clk30) disable iff (reset) bus_ack |=> !bus_ack)
        else begin
            sva_errors++;
            $display("** Error at %0t: bus_ack held for more than one cycle", $time);
        end

    assert property (@(posedge clk30) disable iff (reset) bus_err |-> !bus_ack)
        else begin
            sva_errors++;
            $display("** Error at %0t: bus_err together with bus_ack", $time);
        end

    assert property (@(posedge clk30) disable iff (reset) ext_req == (as && video_area(addr)))
        else begin
            sva_errors++;
            $display("** Error at %0t: ext_req %b for address %h", $time, ext_req, addr);
        end

    // Video memory model, answers after ext_delay wait cycles
    initial begin
        ext_ack <= 1'b0;
        ext_rdata <= 16'h0000;
        forever begin
            @(posedge clk30);
            if (reset || !ext_req || ext_ack) begin
                ext_ack <= 1'b0;
                ext_wait <= 0;
            end else if (ext_wait >= ext_delay) begin
                ext_ack <= 1'b1;
                ext_rdata <= video_fill(ext_addr);
            end else begin
                ext_wait <= ext_wait + 1;
            end
        end
    end

    task automatic check_true(input logic ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("** Error at %0t: %s", $time, msg);
        end
    endtask

    task automatic start_test();
        test_errors = errors;
        test_checks = checks;
    endtask

    task automatic report_test(input string name);
        $display("%s: %0d checks, %0d errors", name, checks - test_checks, errors - test_errors);
    endtask

    task automatic apply_reset();
        @(posedge clk30);
        reset <= 1'b1;
        repeat (5) @(posedge clk30);
        reset <= 1'b0;
    endtask

    // One CPU cycle, strobe held until bus_ack or bus_err
    task automatic bus_cycle(input logic [23:0] a, input logic wr, input logic u, input logic l,
                             input logic [15:0] wd, input logic ack_cycle);
        int waited;
        logic done;
        @(posedge clk30);
        addr <= a;
        as <= 1'b1;
        uds <= u;
        lds <= l;
        write_strobe <= wr;
        wdata <= wd;
        iack4 <= ack_cycle;
        waited = 0;
        done = 1'b0;
        got_cycles = -1;
        got_ack = 1'b0;
        got_err = 1'b0;
        while (!done && waited <= BUS_TIMEOUT) begin
            @(negedge clk30);  // Outputs settled
            if (bus_ack || bus_err) begin
                done = 1'b1;
                got_data = rdata;
                got_ack = bus_ack;
                got_err = bus_err;
                got_cycles = waited;
                got_ext_req = ext_req;
                got_ext_write = ext_write;
                got_ext_addr = ext_addr;
            end else begin
                waited++;
            end
        end
        if (!done) begin
            errors++;
            $display("Timeout: no bus_ack or bus_err for address %h", a);
        end
        @(posedge clk30);
        as <= 1'b0;
        uds <= 1'b0;
        lds <= 1'b0;
        write_strobe <= 1'b0;
        iack4 <= 1'b0;
    endtask

    task automatic drive_irq(input logic cdic, input logic vmpeg);
        @(posedge clk30);
        cdic_intreq <= cdic;
        vmpeg_intreq <= vmpeg;
    endtask

    task automatic wait_int4(input logic level, output int waited);
        waited = 0;
        @(negedge clk30);
        while (int4 !== level && waited < BUS_TIMEOUT) begin
            @(negedge clk30);
            waited++;
        end
        if (int4 !== level) begin
            errors++;
            $display("Timeout: int4 did not reach %b", level);
        end
    endtask

    task automatic irq_ack_check(input logic [15:0] expected, input string what);
        bus_cycle(24'hfffff8, 1'b0, 1'b0, 1'b1, 16'h0000, 1'b1);
        check_true(got_ack && !got_err && got_cycles == 0,
                   $sformatf("%s: vector cycle not acknowledged at once", what));
        check_true(got_data === expected,
                   $sformatf("%s: vector %h, expected %h", what, got_data, expected));
    endtask

    initial begin
        logic [31:0] rnd;
        logic [12:0] idx;
        logic [7:0] value;
        logic [5:0] word_idx;
        logic [23:0] a;
        int wait_cycles;

        reset <= 1'b1;
        addr <= 24'h000000;
        as <= 1'b0;
        uds <= 1'b0;
        lds <= 1'b0;
        write_strobe <= 1'b0;
        wdata <= 16'h0000;
        cd_img_mounted <= 1'b0;  // ROM inactive until test 3
        auto_play <= 1'b0;
        audio_cd_in_tray <= 1'b0;
        slave_reset <= 1'b0;
        cdic_intreq <= 1'b0;
        vmpeg_intreq <= 1'b0;
        iack4 <= 1'b0;
        $readmemh("boot_rom.mem", rom_image);
        rnd = $urandom(32'hedcb);
        apply_reset();

        start_test();
        for (int i = 0; i < NVRAM_WRITES; i++) begin
            rnd = $urandom();
            idx = rnd[12:0];
            value = rnd[23:16];
            nv_model[idx] = value;
            nv_index.push_back(idx);
            bus_cycle({8'h32, 2'b00, idx, 1'b0}, 1'b1, 1'b1, 1'b0, {value, rnd[7:0]}, 1'b0);
            check_true(got_ack && got_cycles == 1, $sformatf("NVRAM write ack at %h", idx));
        end
        foreach (nv_index[k]) begin
            idx = nv_index[k];
            bus_cycle({8'h32, 2'b00, idx, 1'b0}, 1'b0, 1'b1, 1'b1, 16'h0000, 1'b0);
            check_true(got_ack && got_cycles == 1, $sformatf("NVRAM read ack at %h", idx));
            check_true(got_data === {nv_model[idx], nv_model[idx]},
                       $sformatf("NVRAM %h read %h, expected byte %h", idx, got_data, nv_model[idx]));
        end
        idx = nv_index[0];
        a = {8'h32, 2'b00, idx, 1'b0};
        bus_cycle(a, 1'b1, 1'b0, 1'b1, ~{nv_model[idx], nv_model[idx]}, 1'b0);  // Lower lane only
        bus_cycle(a, 1'b0, 1'b1, 1'b1, 16'h0000, 1'b0);
        check_true(got_data === {nv_model[idx], nv_model[idx]},
                   $sformatf("NVRAM %h changed by lds write, read %h", idx, got_data));
        report_test("nvram");

        start_test();
        foreach (err_addrs[k]) begin
            bus_cycle(err_addrs[k], 1'b0, 1'b1, 1'b1, 16'h0000, 1'b0);
            check_true(got_err && !got_ack && got_cycles == 0,
                       $sformatf("no immediate bus error at %h", err_addrs[k]));
        end
        report_test("bus errors");

        start_test();
        @(posedge clk30);
        cd_img_mounted <= 1'b1;
        auto_play <= 1'b1;
        for (int i = 0; i < 53; i++) begin
            word_idx = i[5:0];
            bus_cycle(24'hf00000 + {17'h0, word_idx, 1'b0}, 1'b0, 1'b1, 1'b1, 16'h0000, 1'b0);
            check_true(got_ack && got_cycles == 1, $sformatf("ROM word %0d ack timing", i));
            check_true(got_data === rom_image[word_idx],
                       $sformatf("ROM word %0d read %h, expected %h", i, got_data,
                                 rom_image[word_idx]));
        end
        @(posedge clk30);
        slave_reset <= 1'b1;
        @(posedge clk30);
        slave_reset <= 1'b0;
        bus_cycle(24'hf00010, 1'b0, 1'b1, 1'b1, 16'h0000, 1'b0);
        check_true(got_err && !got_ack, "ROM window still open after slave reset");
        apply_reset();  // Clears the slave latch
        bus_cycle(24'hf00012, 1'b0, 1'b1, 1'b1, 16'h0000, 1'b0);
        check_true(got_ack && got_cycles == 1 && got_data === rom_image[9],
                   "ROM not back after board reset");
        report_test("boot rom");

        start_test();
        drive_irq(1'b1, 1'b0);
        wait_int4(1'b1, wait_cycles);
        check_true(wait_cycles == 1, $sformatf("CDIC owner after %0d cycles", wait_cycles));
        irq_ack_check(CDIC_VEC, "CDIC alone");
        drive_irq(1'b0, 1'b0);
        wait_int4(1'b0, wait_cycles);
        drive_irq(1'b0, 1'b1);
        wait_int4(1'b1, wait_cycles);
        check_true(wait_cycles == 1, $sformatf("VMPEG owner after %0d cycles", wait_cycles));
        irq_ack_check(VMPEG_VEC, "VMPEG alone");
        drive_irq(1'b0, 1'b0);
        wait_int4(1'b0, wait_cycles);
        drive_irq(1'b1, 1'b1);
        wait_int4(1'b1, wait_cycles);
        irq_ack_check(VMPEG_VEC, "both requesting");
        drive_irq(1'b1, 1'b0);  // VMPEG releases, CDIC takes over via idle
        wait_int4(1'b1, wait_cycles);
        check_true(wait_cycles == 2, $sformatf("CDIC handover after %0d cycles", wait_cycles));
        irq_ack_check(CDIC_VEC, "CDIC after VMPEG");
        drive_irq(1'b0, 1'b0);
        wait_int4(1'b0, wait_cycles);
        report_test("level 4 interrupt");

        start_test();
        foreach (video_addrs[k]) begin
            ext_delay = k % 4;
            bus_cycle(video_addrs[k], 1'b0, 1'b1, 1'b1, 16'h0000, 1'b0);
            check_true(got_ack && got_cycles == ext_delay + 1,
                       $sformatf("video %h acked after %0d cycles", video_addrs[k], got_cycles));
            check_true(got_ext_req && !got_ext_write && got_ext_addr === video_addrs[k],
                       $sformatf("video %h not on ext port", video_addrs[k]));
            check_true(got_data === video_fill(video_addrs[k]),
                       $sformatf("video %h read %h", video_addrs[k], got_data));
        end
        ext_delay = 2;
        bus_cycle(24'h400100, 1'b1, 1'b1, 1'b1, 16'hbeef, 1'b0);
        check_true(got_ack && got_ext_write, "video write not forwarded");
        bus_cycle(24'h300000, 1'b0, 1'b1, 1'b1, 16'h0000, 1'b0);
        check_true(got_ack && got_cycles == 0 && got_data === 16'h0000, "open bus at 300000");
        bus_cycle(24'h30abce, 1'b0, 1'b1, 1'b1, 16'h0000, 1'b0);
        check_true(got_ack && got_cycles == 0 && got_data === 16'h0000, "open bus at 30abce");
        report_test("external and open");

        $display("Summary: 5 tests, %0d checks, %0d errors", checks, errors + sva_errors);
        if (errors + sva_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
